// File: logic/i2c_bridge_pkg.sv
// i2c bridge package: shared widths, FIFO sizing, filter defaults and target FSM states
package i2c_bridge_pkg;

    // data byte on the bus, in the buffer and at the host
    typedef logic [7:0] byte_t;

    // 7-bit target address
    typedef logic [6:0] dev_addr_t;

    // buffer sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_ADDR_W = 3;

    // extra msb tells full from empty
    typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

    // input filter length in clock samples
    localparam int FILTER_LEN_DEFAULT = 4;

    localparam dev_addr_t DEV_ADDR_DEFAULT = 7'h50;

    typedef enum logic [2:0] {
        st_idle,
        st_address,
        st_ack,
        st_write_release,
        st_write_bits,
        st_read_bits,
        st_read_release,
        st_read_ack
    } target_state_t;

endpackage

// File: logic/i2c_target.sv
// i2c target: filters the bus, collects written bytes for the buffer and serves read-back
module i2c_target #(
    parameter i2c_bridge_pkg::dev_addr_t DEV_ADDR = i2c_bridge_pkg::DEV_ADDR_DEFAULT,
    parameter int FILTER_LEN = i2c_bridge_pkg::FILTER_LEN_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scl_i,
    output logic                  scl_o,
    input  logic                  sda_i,
    output logic                  sda_o,
    output i2c_bridge_pkg::byte_t wr_data,
    output logic                  wr_req,
    input  logic                  wr_ack,
    input  i2c_bridge_pkg::byte_t rd_data
);

    i2c_bridge_pkg::target_state_t state;
    i2c_bridge_pkg::byte_t shift_reg;
    logic [2:0] bit_cnt;
    logic mode_read;
    logic nack;

    logic [FILTER_LEN-1:0] scl_filt;
    logic [FILTER_LEN-1:0] sda_filt;
    logic scl_lvl;
    logic sda_lvl;
    logic scl_last;
    logic sda_last;

    logic scl_rise;
    logic scl_fall;
    logic sda_rise;
    logic sda_fall;
    logic start_cond;
    logic stop_cond;

    // no clock stretching
    assign scl_o = 1'b1;

    assign scl_rise = scl_lvl && !scl_last;
    assign scl_fall = !scl_lvl && scl_last;
    assign sda_rise = sda_lvl && !sda_last;
    assign sda_fall = !sda_lvl && sda_last;

    // sda moving while scl is high
    assign start_cond = sda_fall && scl_lvl;
    assign stop_cond = sda_rise && scl_lvl;

    always_ff @(posedge clk) begin
        // buffer handshake closes on ack
        if (wr_req && wr_ack) begin
            wr_req <= 1'b0;
        end

        if (start_cond) begin
            sda_o <= 1'b1;
            bit_cnt <= 3'd7;
            state <= i2c_bridge_pkg::st_address;
        end else if (stop_cond) begin
            sda_o <= 1'b1;
            state <= i2c_bridge_pkg::st_idle;
        end else begin
            case (state)
                i2c_bridge_pkg::st_idle: begin
                    sda_o <= 1'b1;
                end
                i2c_bridge_pkg::st_address: begin
                    sda_o <= 1'b1;
                    if (scl_rise) begin
                        if (bit_cnt != 3'd0) begin
                            bit_cnt <= bit_cnt - 3'd1;
                            shift_reg <= {shift_reg[6:0], sda_lvl};
                        end else begin
                            // last bit is r/w
                            mode_read <= sda_lvl;
                            if (shift_reg[6:0] == DEV_ADDR) begin
                                nack <= 1'b0;
                                state <= i2c_bridge_pkg::st_ack;
                            end else begin
                                // not ours, wait for the next start
                                state <= i2c_bridge_pkg::st_idle;
                            end
                        end
                    end
                end
                i2c_bridge_pkg::st_ack: begin
                    if (scl_fall) begin
                        sda_o <= nack;
                        bit_cnt <= 3'd7;
                        if (mode_read) begin
                            shift_reg <= rd_data;
                            state <= i2c_bridge_pkg::st_read_bits;
                        end else begin
                            state <= i2c_bridge_pkg::st_write_release;
                        end
                    end
                end
                i2c_bridge_pkg::st_write_release: begin
                    // end of the ack clock
                    if (scl_fall) begin
                        sda_o <= 1'b1;
                        state <= i2c_bridge_pkg::st_write_bits;
                    end
                end
                i2c_bridge_pkg::st_write_bits: begin
                    sda_o <= 1'b1;
                    if (scl_rise) begin
                        shift_reg <= {shift_reg[6:0], sda_lvl};
                        if (bit_cnt != 3'd0) begin
                            bit_cnt <= bit_cnt - 3'd1;
                        end else begin
                            // byte done, accepted only if the last handshake closed
                            if (!wr_req && !wr_ack) begin
                                wr_data <= {shift_reg[6:0], sda_lvl};
                                wr_req <= 1'b1;
                                nack <= 1'b0;
                            end else begin
                                nack <= 1'b1;
                            end
                            state <= i2c_bridge_pkg::st_ack;
                        end
                    end
                end
                i2c_bridge_pkg::st_read_bits: begin
                    // msb first, one bit per falling scl
                    if (scl_fall) begin
                        {sda_o, shift_reg} <= {shift_reg, 1'b1};
                        if (bit_cnt != 3'd0) begin
                            bit_cnt <= bit_cnt - 3'd1;
                        end else begin
                            state <= i2c_bridge_pkg::st_read_release;
                        end
                    end
                end
                i2c_bridge_pkg::st_read_release: begin
                    if (scl_fall) begin
                        sda_o <= 1'b1;
                        state <= i2c_bridge_pkg::st_read_ack;
                    end
                end
                i2c_bridge_pkg::st_read_ack: begin
                    if (scl_rise) begin
                        if (sda_lvl) begin
                            // controller nack ends the read
                            state <= i2c_bridge_pkg::st_idle;
                        end else begin
                            bit_cnt <= 3'd7;
                            shift_reg <= rd_data;
                            state <= i2c_bridge_pkg::st_read_bits;
                        end
                    end
                end
            endcase
        end

        // glitch filter, level changes only after FILTER_LEN equal samples
        scl_filt <= {scl_filt[FILTER_LEN-2:0], scl_i};
        sda_filt <= {sda_filt[FILTER_LEN-2:0], sda_i};

        if (scl_filt == '1) begin
            scl_lvl <= 1'b1;
        end else if (scl_filt == '0) begin
            scl_lvl <= 1'b0;
        end

        if (sda_filt == '1) begin
            sda_lvl <= 1'b1;
        end else if (sda_filt == '0) begin
            sda_lvl <= 1'b0;
        end

        scl_last <= scl_lvl;
        sda_last <= sda_lvl;

        if (rst) begin
            state <= i2c_bridge_pkg::st_idle;
            sda_o <= 1'b1;
            wr_req <= 1'b0;
            bit_cnt <= 3'd0;
            mode_read <= 1'b0;
            nack <= 1'b0;
            scl_filt <= '1;
            sda_filt <= '1;
            scl_lvl <= 1'b1;
            sda_lvl <= 1'b1;
            scl_last <= 1'b1;
            sda_last <= 1'b1;
        end
    end

    // byte must hold until the buffer has taken it
    wr_data_stable: assert property (@(posedge clk) disable iff (rst)
        wr_req |=> (!wr_req || $stable(wr_data)));

    // new request only after the buffer dropped its ack
    wr_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(wr_req) |-> !wr_ack);

endmodule

// File: logic/byte_fifo.sv
// byte FIFO with eight entries and four-phase req/ack on both sides
module byte_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  i2c_bridge_pkg::byte_t wr_data,
    input  logic                  wr_req,
    output logic                  wr_ack,
    output i2c_bridge_pkg::byte_t fifo_data,
    output logic                  fifo_req,
    input  logic                  fifo_ack
);

    localparam int AW = i2c_bridge_pkg::FIFO_ADDR_W;

    i2c_bridge_pkg::byte_t mem [i2c_bridge_pkg::FIFO_DEPTH];
    i2c_bridge_pkg::fifo_ptr_t wr_ptr;
    i2c_bridge_pkg::fifo_ptr_t rd_ptr;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign empty = (wr_ptr == rd_ptr);
    // same index on the other lap
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // ack is held off while full
    assign push = wr_req && !wr_ack && !full;
    assign pop = fifo_req && fifo_ack;

    // head entry stays put while fifo_req is up
    assign fifo_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        // write side phase
        if (push) begin
            wr_ptr <= wr_ptr + i2c_bridge_pkg::fifo_ptr_t'(1);
            wr_ack <= 1'b1;
        end else if (wr_ack && !wr_req) begin
            wr_ack <= 1'b0;
        end

        // read side phase
        if (pop) begin
            rd_ptr <= rd_ptr + i2c_bridge_pkg::fifo_ptr_t'(1);
            fifo_req <= 1'b0;
        end else if (!fifo_req && !fifo_ack && !empty) begin
            fifo_req <= 1'b1;
        end

        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            wr_ack <= 1'b0;
            fifo_req <= 1'b0;
        end
    end

    // occupancy never goes past the depth
    no_push_full: assert property (@(posedge clk) disable iff (rst)
        i2c_bridge_pkg::fifo_ptr_t'(wr_ptr - rd_ptr) <= i2c_bridge_pkg::FIFO_DEPTH);

    // consumer ack only ever pops a held entry
    no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

// File: logic/host_port.sv
// host port: hands buffered bytes to the host one at a time and keeps the read-back register
module host_port (
    input  logic                  clk,
    input  logic                  rst,
    input  i2c_bridge_pkg::byte_t fifo_data,
    input  logic                  fifo_req,
    output logic                  fifo_ack,
    output i2c_bridge_pkg::byte_t out_data,
    output logic                  out_req,
    input  logic                  out_ack,
    input  i2c_bridge_pkg::byte_t data_in,
    input  logic                  data_latch,
    output i2c_bridge_pkg::byte_t rd_data
);

    // a captured byte not yet delivered
    logic holding;

    always_ff @(posedge clk) begin
        // take a byte only once the host side is idle
        if (!holding && !out_ack && fifo_req && !fifo_ack) begin
            out_data <= fifo_data;
            fifo_ack <= 1'b1;
            holding <= 1'b1;
        end else if (fifo_ack && !fifo_req) begin
            fifo_ack <= 1'b0;
        end

        if (out_req && out_ack) begin
            out_req <= 1'b0;
            holding <= 1'b0;
        end else if (holding && !out_req && !out_ack) begin
            out_req <= 1'b1;
        end

        // host latch beats a delivery in the same cycle
        if (data_latch) begin
            rd_data <= data_in;
        end else if (out_req && out_ack) begin
            rd_data <= out_data;
        end

        if (rst) begin
            fifo_ack <= 1'b0;
            out_req <= 1'b0;
            holding <= 1'b0;
            rd_data <= '0;
        end
    end

    out_data_stable: assert property (@(posedge clk) disable iff (rst)
        out_req |=> (!out_req || $stable(out_data)));

endmodule

// File: logic/i2c_bridge_top.sv
// i2c bridge top: target, byte buffer and host port in a chain
module i2c_bridge_top #(
    parameter i2c_bridge_pkg::dev_addr_t DEV_ADDR = i2c_bridge_pkg::DEV_ADDR_DEFAULT,
    parameter int FILTER_LEN = i2c_bridge_pkg::FILTER_LEN_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  scl_i,
    output logic                  scl_o,
    input  logic                  sda_i,
    output logic                  sda_o,
    output i2c_bridge_pkg::byte_t out_data,
    output logic                  out_req,
    input  logic                  out_ack,
    input  i2c_bridge_pkg::byte_t data_in,
    input  logic                  data_latch
);

    i2c_bridge_pkg::byte_t wr_data;
    logic wr_req;
    logic wr_ack;
    i2c_bridge_pkg::byte_t fifo_data;
    logic fifo_req;
    logic fifo_ack;
    i2c_bridge_pkg::byte_t rd_data;

    i2c_target #(
        .DEV_ADDR  (DEV_ADDR),
        .FILTER_LEN(FILTER_LEN)
    ) u_target (
        .clk    (clk),
        .rst    (rst),
        .scl_i  (scl_i),
        .scl_o  (scl_o),
        .sda_i  (sda_i),
        .sda_o  (sda_o),
        .wr_data(wr_data),
        .wr_req (wr_req),
        .wr_ack (wr_ack),
        .rd_data(rd_data)
    );

    byte_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (wr_data),
        .wr_req   (wr_req),
        .wr_ack   (wr_ack),
        .fifo_data(fifo_data),
        .fifo_req (fifo_req),
        .fifo_ack (fifo_ack)
    );

    host_port u_host (
        .clk       (clk),
        .rst       (rst),
        .fifo_data (fifo_data),
        .fifo_req  (fifo_req),
        .fifo_ack  (fifo_ack),
        .out_data  (out_data),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .data_in   (data_in),
        .data_latch(data_latch),
        .rd_data   (rd_data)
    );

endmodule

// File: verif/tb_bridge_checker.sv
// bridge checker: tracks expected host deliveries and ACK bits, compares and counts results
module tb_bridge_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  out_req,
    input i2c_bridge_pkg::byte_t out_data,
    input logic                  out_ack,
    input logic                  sda_o
);

    i2c_bridge_pkg::byte_t exp_q [$];
    int checks = 0;
    int errors = 0;
    logic req_q = 1'b0;

    task automatic expect_byte(input i2c_bridge_pkg::byte_t b);
        exp_q.push_back(b);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    // target drives low for ACK
    task automatic check_ack(input logic exp_nack);
        check_value("sda_o", {7'd0, sda_o}, {7'd0, exp_nack});
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("%0t %s", $time, msg);
    endtask

    always @(posedge clk) begin
        req_q <= out_req;
        if (!rst && out_req && !req_q && out_ack) begin
            report_fail("out_req rose while out_ack was still high");
        end
        // one cycle with both high closes each delivery
        if (!rst && out_req && out_ack) begin
            if (exp_q.size() == 0) begin
                report_fail($sformatf("unexpected delivery of %02h to the host", out_data));
            end else begin
                check_value("out_data", out_data, exp_q.pop_front());
            end
        end
    end

endmodule

// File: verif/tb_i2c_bridge.sv
// testbench: I2C controller model, host responder and directed tests for the bridge
module tb_i2c_bridge;

    localparam int CLK_PERIOD = 20;
    localparam int BIT_CLKS = 16;
    // start, stop and nine-bit frames of all six tests
    localparam int TEST_BITS = 20 + 65 + 29 + 38 + 119 + 60;
    localparam i2c_bridge_pkg::dev_addr_t ADDR = i2c_bridge_pkg::DEV_ADDR_DEFAULT;
    // host port, FIFO and the target's open request
    localparam int ACCEPT_LIMIT = i2c_bridge_pkg::FIFO_DEPTH + 2;

    logic clk;
    logic rst;
    logic ctrl_scl;
    logic ctrl_sda;
    logic scl_i;
    logic sda_i;
    logic scl_o;
    logic sda_o;
    i2c_bridge_pkg::byte_t out_data;
    logic out_req;
    logic out_ack;
    i2c_bridge_pkg::byte_t data_in;
    logic data_latch;
    logic host_stall;
    logic [31:0] lfsr_state;
    i2c_bridge_pkg::byte_t rand_data [24];
    i2c_bridge_pkg::byte_t exp_readback;
    int err_mark;
    int tests_passed;

    // wired-AND bus
    assign scl_i = ctrl_scl & scl_o;
    assign sda_i = ctrl_sda & sda_o;

    i2c_bridge_top #(
        .DEV_ADDR  (ADDR),
        .FILTER_LEN(i2c_bridge_pkg::FILTER_LEN_DEFAULT)
    ) dut (
        .clk(clk), .rst(rst), .scl_i(scl_i), .scl_o(scl_o), .sda_i(sda_i), .sda_o(sda_o),
        .out_data(out_data), .out_req(out_req), .out_ack(out_ack),
        .data_in(data_in), .data_latch(data_latch)
    );

    tb_bridge_checker chk (
        .clk(clk), .rst(rst), .out_req(out_req), .out_data(out_data),
        .out_ack(out_ack), .sda_o(sda_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(2 * TEST_BITS * BIT_CLKS * CLK_PERIOD);
        $display("timeout: the tests did not finish within twice their bus time");
        $display("Simulation failed");
        $finish;
    end

    // galois lfsr, one step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    // byte idx of a write is accepted unless the host stalls and every stage is full
    function automatic logic ref_accept(input int idx, input logic stalled);
        return !stalled || idx < ACCEPT_LIMIT;
    endfunction

    // 16 clocks, data changes mid low phase, sampled mid high phase
    task automatic clock_bit(input logic b, output logic sampled);
        @(posedge clk);
        ctrl_scl <= 1'b0;
        repeat (4) @(posedge clk);
        ctrl_sda <= b;
        repeat (4) @(posedge clk);
        ctrl_scl <= 1'b1;
        repeat (4) @(posedge clk);
        sampled = sda_i;
        repeat (3) @(posedge clk);
    endtask

    task automatic start_cond();
        @(posedge clk);
        ctrl_sda <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic stop_cond();
        @(posedge clk);
        ctrl_scl <= 1'b0;
        repeat (4) @(posedge clk);
        ctrl_sda <= 1'b0;
        repeat (4) @(posedge clk);
        ctrl_scl <= 1'b1;
        repeat (8) @(posedge clk);
        ctrl_sda <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic send_byte(input i2c_bridge_pkg::byte_t b, input logic exp_nack);
        logic s;
        for (int k = 7; k >= 0; k--) begin
            clock_bit(b[k], s);
        end
        clock_bit(1'b1, s);
        chk.check_ack(exp_nack);
    endtask

    task automatic write_check(input i2c_bridge_pkg::dev_addr_t addr, input int first,
                               input int n, input logic stalled);
        logic ok;
        start_cond();
        send_byte({addr, 1'b0}, addr != ADDR);
        for (int i = 0; i < n; i++) begin
            ok = (addr == ADDR) && ref_accept(i, stalled);
            if (ok) begin
                chk.expect_byte(rand_data[first + i]);
                exp_readback = rand_data[first + i];
            end
            send_byte(rand_data[first + i], !ok);
        end
        stop_cond();
    endtask

    task automatic read_check(input int n);
        i2c_bridge_pkg::byte_t b;
        logic s;
        start_cond();
        send_byte({ADDR, 1'b1}, 1'b0);
        for (int i = 0; i < n; i++) begin
            for (int k = 7; k >= 0; k--) begin
                clock_bit(1'b1, s);
                b[k] = s;
            end
            // nack on the last byte only
            clock_bit(i == n - 1, s);
            chk.check_value("sda read byte", b, exp_readback);
        end
        stop_cond();
        chk.check_value("sda_o", {7'd0, sda_o}, 8'd1);
    endtask

    task automatic latch_value(input i2c_bridge_pkg::byte_t v);
        @(posedge clk);
        data_in <= v;
        data_latch <= 1'b1;
        @(posedge clk);
        data_latch <= 1'b0;
        exp_readback = v;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        repeat (32) @(posedge clk);
        while ((chk.pending() != 0 || out_req || out_ack) && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (n >= 2000) begin
            chk.report_fail("host deliveries did not finish in time");
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (chk.errors == err_mark) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, chk.errors - err_mark);
        end
        err_mark = chk.errors;
    endtask

    initial begin : host_responder
        int delay;
        forever begin
            @(posedge clk);
            if (out_req && !out_ack && !host_stall) begin
                delay = take_bits(3);
                repeat (delay) @(posedge clk);
                out_ack <= 1'b1;
                while (out_req) begin
                    @(posedge clk);
                end
                out_ack <= 1'b0;
            end
        end
    end

    initial begin
        rst = 1'b1;
        ctrl_scl = 1'b1;
        ctrl_sda = 1'b1;
        out_ack = 1'b0;
        data_in = '0;
        data_latch = 1'b0;
        host_stall = 1'b0;
        lfsr_state = 32'h9139;
        exp_readback = '0;
        err_mark = 0;
        tests_passed = 0;
        for (int i = 0; i < 24; i++) begin
            rand_data[i] = take_bits(8);
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        chk.check_value("scl_o", {7'd0, scl_o}, 8'd1);
        chk.check_value("sda_o", {7'd0, sda_o}, 8'd1);
        chk.check_value("out_req", {7'd0, out_req}, 8'd0);
        read_check(1);
        end_test(1, "reset state");

        write_check(ADDR, 0, 6, 1'b0);
        wait_drained();
        end_test(2, "write burst");

        write_check(ADDR ^ 7'h0a, 6, 2, 1'b0);
        wait_drained();
        end_test(3, "foreign address");

        read_check(3);
        end_test(4, "repeated read-back");

        host_stall <= 1'b1;
        write_check(ADDR, 8, 12, 1'b1);
        host_stall <= 1'b0;
        wait_drained();
        end_test(5, "host stall");

        latch_value(rand_data[20]);
        read_check(1);
        write_check(ADDR, 21, 1, 1'b0);
        wait_drained();
        read_check(1);
        end_test(6, "read-back latch");

        $display("tests passed: %0d of 6, checks: %0d, errors: %0d",
                 tests_passed, chk.checks, chk.errors);
        if (chk.errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
logic/i2c_bridge_pkg.sv
logic/i2c_target.sv
logic/byte_fifo.sv
logic/host_port.sv
logic/i2c_bridge_top.sv
verif/tb_bridge_checker.sv
verif/tb_i2c_bridge.sv

// File: Bender.yml
package:
  name: i2c_bridge

sources:
  - logic/i2c_bridge_pkg.sv
  - logic/i2c_target.sv
  - logic/byte_fifo.sv
  - logic/host_port.sv
  - logic/i2c_bridge_top.sv
  - target: simulation
    files:
      - verif/tb_bridge_checker.sv
      - verif/tb_i2c_bridge.sv
